// ==== hdl/neoIoPkg.sv ====
package neoIoPkg;

	// I/O zone codes, taken from A21 to A17 of the 68000 address
	// The comment on each value is the matching base address
	typedef enum logic [4:0] {
		// $300000 P1 input, DIP switch on the odd byte
		zoneP1    = 5'h18,
		// $320000 sound latch, reads as $FF here
		zoneSound = 5'h19,
		// $340000 P2 input
		zoneP2    = 5'h1A,
		// $380000 status B read, write registers on the odd byte
		zoneBitw0 = 5'h1C,
		// $3A0000 system latch
		zoneBitw1 = 5'h1D
	} ioZone_e;

	// Write register select inside zoneBitw0, from A6 to A4
	typedef enum logic [2:0] {
		selPoutput  = 3'd0,
		selCrdBank  = 3'd1,
		selSlot     = 3'd2,
		selLedLatch = 3'd3,
		selLedData  = 3'd4,
		// RTC control, not modelled
		selRtc      = 3'd5,
		selCoinA    = 3'd6,
		selCoinB    = 3'd7
	} ioSel_e;

	// Register view of A7 to A0
	typedef struct packed {
		logic       hiBit;
		ioSel_e     sel;
		logic [3:0] low;
	} ioRegView_s;

	// Coin command view of A7 to A0
	typedef struct packed {
		logic       unused7;
		logic [1:0] zoneBits;
		logic       setNotClr;
		logic       unused3;
		logic       lockout;
		logic       player;
		logic       odd;
	} ioCoinView_s;

	// One address byte, two decodes
	typedef union packed {
		ioRegView_s  regView;
		ioCoinView_s coinView;
	} ioOffset_u;

endpackage

// ==== hdl/ioBusIf.sv ====
`timescale 1ns/1ps

interface ioBusIf;
	import neoIoPkg::*;

	// One-cycle write strobes, at most one high
	logic portWr;
	logic panelWr;
	logic coinWr;
	logic sysWr;
	// Read strobe for DIP switch and status B
	logic panelRd;
	// Latched A7 to A0 of the access
	ioOffset_u offset;
	// Lower lane write byte
	logic [7:0] wdata;
	// Panel read byte, combinational from offset
	logic [7:0] panelRdata;

	modport decode (output portWr, panelWr, coinWr, sysWr, panelRd, offset, wdata,
		input panelRdata);
	modport portOut (input portWr, offset, wdata);
	modport panel (input panelWr, panelRd, offset, wdata, output panelRdata);
	modport coin (input coinWr, offset);
	modport sysl (input sysWr, offset);

endinterface

// ==== hdl/neoIoDecode.sv ====
`timescale 1ns/1ps

module neoIoDecode #(
	parameter int waitStates = 0
) (
	input  logic        clk24M,
	input  logic        rstN,
	input  logic [22:0] busAddr,
	input  logic [15:0] busDin,
	input  logic        busRw,
	input  logic        asN,
	input  logic        udsN,
	input  logic        ldsN,
	input  logic [9:0]  p1In,
	input  logic [9:0]  p2In,
	output logic [15:0] busDout,
	output logic        dtackN,
	ioBusIf.decode      io
);
	import neoIoPkg::*;

	// FSM codes
	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stWait = 2'd1;
	localparam logic [1:0] stStrobe = 2'd2;
	localparam logic [1:0] stAck = 2'd3;
	// Wait counter counts down from waitStates-1
	localparam int cntW = (waitStates > 1) ? $clog2(waitStates) : 1;

	logic [1:0] state;
	logic [cntW-1:0] waitCnt;
	ioZone_e zoneReg;
	logic rwReg;
	logic inArea;
	logic inStrobe;
	logic oddLane;
	logic wrLow;
	logic bitw0Wr;
	logic [7:0] readByte;

	// A23 and A22 low, A21 to A17 on a known zone
	always_comb begin
		inArea = 1'b0;
		if (busAddr[22:21] == 2'b00) begin
			case (busAddr[20:16])
				zoneP1, zoneSound, zoneP2, zoneBitw0, zoneBitw1: inArea = 1'b1;
				default: inArea = 1'b0;
			endcase
		end
	end

	// Control state
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			waitCnt <= '0;
			zoneReg <= zoneSound;
			rwReg <= 1'b1;
			dtackN <= 1'b1;
			busDout <= 16'hFFFF;
		end else begin
			case (state)
				stIdle: begin
					// Edge 1, access needs at least one lane strobed
					if (!asN && inArea && (!udsN || !ldsN)) begin
						zoneReg <= ioZone_e'(busAddr[20:16]);
						rwReg <= busRw;
						if (waitStates == 0) begin
							state <= stStrobe;
						end else begin
							state <= stWait;
							waitCnt <= cntW'(waitStates - 1);
						end
					end
				end
				stWait: begin
					if (waitCnt == '0) begin
						state <= stStrobe;
					end else begin
						waitCnt <= waitCnt - 1'b1;
					end
				end
				stStrobe: begin
					// Units take the strobe on this edge
					state <= stAck;
					dtackN <= 1'b0;
					// Unused lane floats high
					if (rwReg) begin
						busDout <= oddLane ? {8'hFF, readByte} : {readByte, 8'hFF};
					end
				end
				default: begin
					// Hold acknowledge until the master lets go of AS
					if (asN) begin
						state <= stIdle;
						dtackN <= 1'b1;
						busDout <= 16'hFFFF;
					end
				end
			endcase
		end
	end

	// Address byte and write data, latched on edge 1
	always_ff @(posedge clk24M) begin
		if (state == stIdle && !asN) begin
			// A0 is the odd lane whenever LDS is active
			io.offset <= ioOffset_u'({busAddr[6:0], ~ldsN});
			io.wdata <= busDin[7:0];
		end
	end

	assign inStrobe = (state == stStrobe);
	assign oddLane = io.offset.regView.low[0];
	// Only lower lane writes reach the units
	assign wrLow = inStrobe && !rwReg && oddLane;
	assign bitw0Wr = wrLow && (zoneReg == zoneBitw0);

	// Write strobe fan-out by register select
	assign io.portWr = bitw0Wr && (io.offset.regView.sel inside {selPoutput, selCrdBank});
	assign io.panelWr = bitw0Wr &&
		(io.offset.regView.sel inside {selSlot, selLedLatch, selLedData});
	assign io.coinWr = bitw0Wr && (io.offset.regView.sel inside {selCoinA, selCoinB});
	assign io.sysWr = wrLow && (zoneReg == zoneBitw1);
	// DIP switch sits on P1 odd, status B on bitw0 even
	assign io.panelRd = inStrobe && rwReg &&
		(((zoneReg == zoneP1) && oddLane) || ((zoneReg == zoneBitw0) && !oddLane));

	// Read byte for the active lane
	always_comb begin
		case (zoneReg)
			zoneP1: readByte = oddLane ? io.panelRdata : p1In[7:0];
			zoneP2: readByte = oddLane ? 8'hFF : p2In[7:0];
			zoneBitw0: readByte = oddLane ? 8'hFF : io.panelRdata;
			default: readByte = 8'hFF;
		endcase
	end

	// Never more than one unit written per access
	assert property (@(posedge clk24M) disable iff (!rstN)
		$onehot0({io.portWr, io.panelWr, io.coinWr, io.sysWr}));

	// Acknowledge only inside a live bus cycle
	assert property (@(posedge clk24M) disable iff (!rstN)
		!dtackN |-> $past(!asN));

endmodule

// ==== hdl/neoPortOut.sv ====
`timescale 1ns/1ps

module neoPortOut (
	input  logic       clk24M,
	input  logic       rstN,
	ioBusIf.portOut    io,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [2:0] cardBank
);
	import neoIoPkg::*;

	// Joypad outputs and memory card bank
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			p1Out <= 3'd0;
			p2Out <= 3'd0;
			cardBank <= 3'd0;
		end else if (io.portWr) begin
			case (io.offset.regView.sel)
				selPoutput: begin
					// Both pads from one byte
					p1Out <= io.wdata[2:0];
					p2Out <= io.wdata[5:3];
				end
				selCrdBank: begin
					cardBank <= io.wdata[2:0];
				end
				default: begin
					// Other selects go elsewhere
					p1Out <= p1Out;
				end
			endcase
		end
	end

endmodule

// ==== hdl/neoSysPanel.sv ====
`timescale 1ns/1ps

module neoSysPanel (
	input  logic       clk24M,
	input  logic       rstN,
	ioBusIf.panel      io,
	input  logic [7:0] dipsw,
	input  logic       testBtnN,
	input  logic [9:0] p1In,
	input  logic [9:0] p2In,
	output logic [7:0] ledOut1,
	output logic [7:0] ledOut2
);
	import neoIoPkg::*;

	logic [2:0] slot;
	logic [7:0] ledData;
	logic [7:0] statusB;

	// Slot select, LED data byte and the two LED latches
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			slot <= 3'd0;
			ledData <= 8'd0;
			ledOut1 <= 8'd0;
			ledOut2 <= 8'd0;
		end else if (io.panelWr) begin
			case (io.offset.regView.sel)
				selSlot: begin
					slot <= io.wdata[2:0];
				end
				selLedData: begin
					ledData <= io.wdata;
				end
				selLedLatch: begin
					// Each latch copies on its own bit
					if (io.wdata[4]) begin
						ledOut1 <= ledData;
					end
					if (io.wdata[5]) begin
						ledOut2 <= ledData;
					end
				end
				default: begin
					slot <= slot;
				end
			endcase
		end
	end

	// Top bits of both pads, test button, current slot
	assign statusB = {p2In[9:8], p1In[9:8], testBtnN, slot};

	// Odd lane is the DIP switch, even lane is status B
	assign io.panelRdata = io.offset.regView.low[0] ? dipsw : statusB;

	// A read and a write never share one access
	assert property (@(posedge clk24M) disable iff (!rstN)
		!(io.panelRd && io.panelWr));

endmodule

// ==== hdl/neoCoinLatch.sv ====
`timescale 1ns/1ps

module neoCoinLatch (
	input  logic       clk24M,
	input  logic       rstN,
	ioBusIf.coin       io,
	output logic [1:0] coinCounter,
	output logic [1:0] coinLockout
);

	// Four set/reset latches with one bit per command
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			coinCounter <= 2'b00;
			coinLockout <= 2'b00;
		end else if (io.coinWr) begin
			// A2 picks lockout over counter and A1 picks the player
			if (io.offset.coinView.lockout) begin
				coinLockout[io.offset.coinView.player] <= io.offset.coinView.setNotClr;
			end else begin
				coinCounter[io.offset.coinView.player] <= io.offset.coinView.setNotClr;
			end
		end
	end

endmodule

// ==== hdl/sysLatch.sv ====
`timescale 1ns/1ps

module sysLatch (
	input  logic       clk24M,
	input  logic       rstN,
	ioBusIf.sysl       io,
	output logic [7:0] sysFlags
);

	logic [2:0] bitSel;
	logic bitVal;

	// Bit number on A3 to A1
	assign bitSel = io.offset.regView.low[3:1];
	// New value on A4, data bus not used
	assign bitVal = io.offset.regView.sel[0];

	// Addressable latch, untouched bits hold
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			sysFlags <= 8'd0;
		end else if (io.sysWr) begin
			sysFlags[bitSel] <= bitVal;
		end
	end

endmodule

// ==== hdl/neoIoTop.sv ====
`timescale 1ns/1ps

module neoIoTop #(
	parameter int waitStates = 0
) (
	input  logic        clk24M,
	input  logic        rstN,
	// 68000 bus, A23 to A1
	input  logic [22:0] busAddr,
	input  logic [15:0] busDin,
	output logic [15:0] busDout,
	input  logic        busRw,
	input  logic        asN,
	input  logic        udsN,
	input  logic        ldsN,
	output logic        dtackN,
	// Panel inputs
	input  logic [9:0]  p1In,
	input  logic [9:0]  p2In,
	input  logic [7:0]  dipsw,
	input  logic        testBtnN,
	// Latched outputs
	output logic [2:0]  p1Out,
	output logic [2:0]  p2Out,
	output logic [2:0]  cardBank,
	output logic [7:0]  ledOut1,
	output logic [7:0]  ledOut2,
	output logic [1:0]  coinCounter,
	output logic [1:0]  coinLockout,
	output logic [7:0]  sysFlags
);

	// Decoder to unit strobes
	ioBusIf ioBus ();

	neoIoDecode #(
		.waitStates(waitStates)
	) decode_i (
		.clk24M (clk24M),
		.rstN   (rstN),
		.busAddr(busAddr),
		.busDin (busDin),
		.busRw  (busRw),
		.asN    (asN),
		.udsN   (udsN),
		.ldsN   (ldsN),
		.p1In   (p1In),
		.p2In   (p2In),
		.busDout(busDout),
		.dtackN (dtackN),
		.io     (ioBus)
	);

	neoPortOut portOut_i (
		.clk24M  (clk24M),
		.rstN    (rstN),
		.io      (ioBus),
		.p1Out   (p1Out),
		.p2Out   (p2Out),
		.cardBank(cardBank)
	);

	neoSysPanel panel_i (
		.clk24M  (clk24M),
		.rstN    (rstN),
		.io      (ioBus),
		.dipsw   (dipsw),
		.testBtnN(testBtnN),
		.p1In    (p1In),
		.p2In    (p2In),
		.ledOut1 (ledOut1),
		.ledOut2 (ledOut2)
	);

	neoCoinLatch coin_i (
		.clk24M     (clk24M),
		.rstN       (rstN),
		.io         (ioBus),
		.coinCounter(coinCounter),
		.coinLockout(coinLockout)
	);

	sysLatch sysl_i (
		.clk24M  (clk24M),
		.rstN    (rstN),
		.io      (ioBus),
		.sysFlags(sysFlags)
	);

endmodule

// ==== verification/neoIoTb.sv ====
`timescale 1ns/1ps

module neoIoTb;

	localparam int waitStates = 2;
	// Cycles from the first AS sample to DTACK low
	localparam int ackLatency = 2 + waitStates;
	localparam int ackTimeout = 20;
	// Zone base addresses of the I/O area
	localparam logic [23:0] p1Base = 24'h300000;
	localparam logic [23:0] p2Base = 24'h340000;
	localparam logic [23:0] bitw0Base = 24'h380000;
	localparam logic [23:0] bitw1Base = 24'h3A0000;
	localparam logic [23:0] readBases [4] = '{24'h300000, 24'h320000, 24'h340000, 24'h380000};

	logic clk24M;
	logic rstN;
	logic [22:0] busAddr;
	logic [15:0] busDin;
	logic [15:0] busDout;
	logic busRw;
	logic asN;
	logic udsN;
	logic ldsN;
	logic dtackN;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic [7:0] dipsw;
	logic testBtnN;
	logic [2:0] p1Out;
	logic [2:0] p2Out;
	logic [2:0] cardBank;
	logic [7:0] ledOut1;
	logic [7:0] ledOut2;
	logic [1:0] coinCounter;
	logic [1:0] coinLockout;
	logic [7:0] sysFlags;

	// Register model
	logic [2:0] mP1Out;
	logic [2:0] mP2Out;
	logic [2:0] mCardBank;
	logic [2:0] mSlot;
	logic [7:0] mLedData;
	logic [7:0] mLed1;
	logic [7:0] mLed2;
	logic [1:0] mCoinCnt;
	logic [1:0] mCoinLock;
	logic [7:0] mSysFlags;
	logic [31:0] lcgState;

	neoIoTop #(
		.waitStates(waitStates)
	) dut_i (
		.clk24M     (clk24M),
		.rstN       (rstN),
		.busAddr    (busAddr),
		.busDin     (busDin),
		.busDout    (busDout),
		.busRw      (busRw),
		.asN        (asN),
		.udsN       (udsN),
		.ldsN       (ldsN),
		.dtackN     (dtackN),
		.p1In       (p1In),
		.p2In       (p2In),
		.dipsw      (dipsw),
		.testBtnN   (testBtnN),
		.p1Out      (p1Out),
		.p2Out      (p2Out),
		.cardBank   (cardBank),
		.ledOut1    (ledOut1),
		.ledOut2    (ledOut2),
		.coinCounter(coinCounter),
		.coinLockout(coinLockout),
		.sysFlags   (sysFlags)
	);

	initial begin
		clk24M = 1'b0;
		forever begin
			#2 clk24M = ~clk24M;
		end
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Odd lane access at a bitw0 style register, random A15 to A8, A7 and A3 to A1
	function automatic logic [23:0] regAddr(input logic [23:0] base, input logic [2:0] sel,
		input logic [31:0] r);
		return base | {8'h00, r[15:8], r[23], sel, r[19:17], 1'b1};
	endfunction

	// Expected read byte on the strobed lane
	function automatic logic [7:0] refRead(input logic [23:0] a);
		logic [4:0] zone;
		zone = a[21:17];
		if (a[23:22] != 2'b00)
			return 8'hFF;
		if (zone == p1Base[21:17])
			return a[0] ? dipsw : p1In[7:0];
		if (zone == p2Base[21:17] && !a[0])
			return p2In[7:0];
		if (zone == bitw0Base[21:17] && !a[0])
			return {p2In[9:8], p1In[9:8], testBtnN, mSlot};
		return 8'hFF;
	endfunction

	// Model update, lower lane only
	function automatic void modelWrite(input logic [23:0] a, input logic [7:0] d);
		if (a[23:22] == 2'b00 && a[0]) begin
			if (a[21:17] == bitw0Base[21:17]) begin
				case (a[6:4])
					3'd0: begin
						mP1Out = d[2:0];
						mP2Out = d[5:3];
					end
					3'd1: mCardBank = d[2:0];
					3'd2: mSlot = d[2:0];
					3'd3: begin
						if (d[4])
							mLed1 = mLedData;
						if (d[5])
							mLed2 = mLedData;
					end
					3'd4: mLedData = d;
					// A2 picks lockout, A1 the player, A4 the new value
					3'd6, 3'd7: begin
						if (a[2])
							mCoinLock[a[1]] = a[4];
						else
							mCoinCnt[a[1]] = a[4];
					end
					default: ;
				endcase
			end else if (a[21:17] == bitw1Base[21:17]) begin
				mSysFlags[a[3:1]] = a[4];
			end
		end
	endfunction

	task automatic stopWithError(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stopWithError($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic checkOutputs();
		checkEq("p1Out", 32'(p1Out), 32'(mP1Out));
		checkEq("p2Out", 32'(p2Out), 32'(mP2Out));
		checkEq("cardBank", 32'(cardBank), 32'(mCardBank));
		checkEq("ledOut1", 32'(ledOut1), 32'(mLed1));
		checkEq("ledOut2", 32'(ledOut2), 32'(mLed2));
		checkEq("coinCounter", 32'(coinCounter), 32'(mCoinCnt));
		checkEq("coinLockout", 32'(coinLockout), 32'(mCoinLock));
		checkEq("sysFlags", 32'(sysFlags), 32'(mSysFlags));
	endtask

	// One bus cycle on a single lane, called on a falling edge
	task automatic busAccess(input logic [23:0] a, input logic rw, input logic [7:0] wByte,
		output logic [15:0] rWord);
		int cycles;
		cycles = 0;
		busAddr = a[23:1];
		busRw = rw;
		busDin = {wByte, wByte};
		udsN = a[0];
		ldsN = ~a[0];
		asN = 1'b0;
		while (dtackN !== 1'b0) begin
			@(negedge clk24M);
			cycles++;
			if (cycles > ackTimeout)
				stopWithError("DTACK never came for an I/O access");
		end
		checkEq("ackLatency", 32'(cycles), 32'(ackLatency));
		rWord = busDout;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		// DTACK must rise one edge after AS goes high
		cycles = 0;
		while (dtackN !== 1'b1) begin
			@(negedge clk24M);
			cycles++;
			if (cycles > 4)
				stopWithError("DTACK stayed low after AS was released");
		end
		checkEq("dtackRelease", 32'(cycles), 32'd1);
	endtask

	task automatic busWrite(input logic [23:0] a, input logic [7:0] d);
		logic [15:0] unusedWord;
		modelWrite(a, d);
		busAccess(a, 1'b0, d, unusedWord);
		checkOutputs();
	endtask

	task automatic busRead(input logic [23:0] a);
		logic [15:0] word;
		logic [7:0] expByte;
		expByte = refRead(a);
		busAccess(a, 1'b1, 8'h00, word);
		// The lane that is not strobed reads all ones
		checkEq("busDout", 32'(word), a[0] ? {16'h0, 8'hFF, expByte} : {16'h0, expByte, 8'hFF});
	endtask

	// Access outside the area, DTACK must stay high
	task automatic outsideWrite(input logic [23:0] a, input logic [7:0] d);
		busAddr = a[23:1];
		busRw = 1'b0;
		busDin = {d, d};
		ldsN = 1'b0;
		asN = 1'b0;
		for (int c = 0; c < 8; c++) begin
			@(negedge clk24M);
			checkEq("dtackN", 32'(dtackN), 32'd1);
		end
		asN = 1'b1;
		ldsN = 1'b1;
		@(negedge clk24M);
		checkEq("busDout", 32'(busDout), 32'hFFFF);
		checkOutputs();
	endtask

	initial begin
		logic [31:0] r;
		lcgState = 32'd91291;
		rstN = 1'b0;
		busAddr = '0;
		busDin = '0;
		busRw = 1'b1;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		p1In = '0;
		p2In = '0;
		dipsw = '0;
		testBtnN = 1'b1;
		{mP1Out, mP2Out, mCardBank, mSlot, mLedData, mLed1, mLed2} = '0;
		{mCoinCnt, mCoinLock, mSysFlags} = '0;
		repeat (4) @(negedge clk24M);
		rstN = 1'b1;
		@(negedge clk24M);
		checkEq("dtackN", 32'(dtackN), 32'd1);
		checkEq("busDout", 32'(busDout), 32'hFFFF);
		checkOutputs();

		// Panel reads with a fresh slot and fresh inputs each time
		for (int i = 0; i < 40; i++) begin
			r = nextRand();
			busWrite(regAddr(bitw0Base, 3'd2, r), r[31:24]);
			r = nextRand();
			p1In = r[9:0];
			p2In = r[19:10];
			dipsw = r[27:20];
			testBtnN = r[28];
			r = nextRand();
			busRead(readBases[r[1:0]] | {8'h00, r[17:3], r[2]});
		end

		// Register writes, about one in four on the upper lane
		for (int i = 0; i < 80; i++) begin
			r = nextRand();
			if (r[21:20] == 2'b00)
				busWrite(regAddr(bitw0Base, 3'(r % 32'd5), r) & 24'hFFFFFE, r[31:24]);
			else
				busWrite(regAddr(bitw0Base, 3'(r % 32'd5), r), r[31:24]);
		end

		// Coin commands sit at A6=A5=1
		for (int i = 0; i < 40; i++) begin
			r = nextRand();
			busWrite(regAddr(bitw0Base, {2'b11, r[4]}, r), r[31:24]);
		end

		for (int i = 0; i < 40; i++) begin
			r = nextRand();
			busWrite(regAddr(bitw1Base, r[6:4], r), r[31:24]);
		end

		// Unused zone, high A22, high A23, zone outside the list
		r = nextRand();
		outsideWrite(24'h360001, r[7:0]);
		outsideWrite(24'h7A0001, r[15:8]);
		outsideWrite(24'hB80001, r[23:16]);
		outsideWrite(24'h200001, r[31:24]);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/neoIoPkg.sv
hdl/ioBusIf.sv
hdl/neoIoDecode.sv
hdl/neoPortOut.sv
hdl/neoSysPanel.sv
hdl/neoCoinLatch.sv
hdl/sysLatch.sv
hdl/neoIoTop.sv
verification/neoIoTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module neoIoTb -o VneoIoTb
./obj_dir/VneoIoTb | tee sim.log
if grep -q "sim failed" sim.log; then
	exit 1
fi
grep -q "sim passed" sim.log
